/* build.f */
+incdir+hdl
hdl/bp_pkg.sv
hdl/btb_table.sv
hdl/btb_update_ctrl.sv
hdl/fetch_pc_gen.sv
hdl/branch_predictor_top.sv
test/tb_clock_gen.sv
test/branch_predictor_assertions.sv
test/branch_predictor_tb.sv

/* hdl/bp_defines.svh */
// ----------------------------------------------------------
// sizing macros for the fetch-side branch predictor
// include wherever table geometry or pc width is needed
// ----------------------------------------------------------
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// instruction address width
`define BP_ADDR_W   32

// btb depth, direct mapped
`define BP_ENTRIES  64

// index bits, taken from pc just above the byte offset
`define BP_IDX_W    6

// tag is whatever is left above index and offset
`define BP_TAG_W    (`BP_ADDR_W - `BP_IDX_W - 2)

// first fetch address after reset
`define BP_RESET_PC 32'h0000_0000

`endif

/* hdl/bp_pkg.sv */
// ----------------------------------------------------------
// shared types for the branch predictor
// import with bp_pkg::* in the module header
// ----------------------------------------------------------
`include "bp_defines.svh"

package bp_pkg;

  // 2-bit saturating direction counter, msb set means taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_e;

  // four-phase update receiver states
  typedef enum logic [1:0] {
    idle     = 2'b00,  // waiting for upd_req
    write    = 2'b01,  // table write cycle
    hold_ack = 2'b10   // ack high until req drops
  } upd_state_e;

  // one btb entry, 59 bits
  typedef struct packed {
    logic                  valid;
    logic [`BP_TAG_W-1:0]  tag;
    logic [`BP_ADDR_W-1:0] target;
    ctr_e                  ctr;
  } btb_entry_t;

  // lookup result for the current fetch pc, 36 bits
  typedef struct packed {
    logic                  hit;
    logic                  taken;
    logic [`BP_ADDR_W-1:0] target;
    ctr_e                  ctr;
  } pred_t;

  // resolved branch from the later stage, 65 bits
  typedef struct packed {
    logic [`BP_ADDR_W-1:0] pc;
    logic [`BP_ADDR_W-1:0] target;
    logic                  taken;
  } resolve_t;

  // fetch redirect, 33 bits
  typedef struct packed {
    logic                  valid;
    logic [`BP_ADDR_W-1:0] pc;
  } redirect_t;

endpackage

/* hdl/branch_predictor_top.sv */
// ----------------------------------------------------------
// branch predictor top, btb plus update ctrl plus fetch pc
// fetch_pc is looked up every cycle, pred leaves comb
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predictor_top
  import bp_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        fetch_en,
  input  redirect_t   redirect,
  input  logic        upd_req,    // four-phase request from the resolver
  input  resolve_t    upd,
  output logic        upd_ack,
  output logic [31:0] fetch_pc,
  output pred_t       pred
);

  // table <-> update ctrl
  logic [`BP_IDX_W-1:0] rd_idx;
  btb_entry_t           rd_entry;
  logic                 wr_en;
  logic [`BP_IDX_W-1:0] wr_idx;
  btb_entry_t           wr_entry;

  btb_table u_btb_table (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (fetch_pc),   // same-cycle lookup of the fetch address
    .pred      (pred),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_entry  (wr_entry),
    .rd_idx    (rd_idx),
    .rd_entry  (rd_entry)
  );

  btb_update_ctrl u_btb_update_ctrl (
    .clk      (clk),
    .reset    (reset),
    .upd_req  (upd_req),
    .upd      (upd),
    .upd_ack  (upd_ack),
    .rd_idx   (rd_idx),
    .rd_entry (rd_entry),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_entry (wr_entry)
  );

  fetch_pc_gen u_fetch_pc_gen (
    .clk      (clk),
    .reset    (reset),
    .fetch_en (fetch_en),
    .redirect (redirect),
    .pred     (pred),        // also goes out of the top
    .fetch_pc (fetch_pc)
  );

endmodule

/* hdl/btb_table.sv */
// ----------------------------------------------------------
// direct-mapped branch target buffer storage
// async lookup and rmw read ports, one synchronous write port
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bp_defines.svh"

module btb_table
  import bp_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [31:0]          lookup_pc,  // current fetch pc
  output pred_t                pred,       // prediction for lookup_pc
  input  logic                 wr_en,      // write strobe from update ctrl
  input  logic [5:0]           wr_idx,
  input  btb_entry_t           wr_entry,
  input  logic [5:0]           rd_idx,     // rmw read index
  output btb_entry_t           rd_entry
);

  // per-entry valid bits, cleared on reset
  logic [`BP_ENTRIES-1:0] valid_q;

  // payload arrays
  logic [`BP_TAG_W-1:0]  tag_mem [0:`BP_ENTRIES-1];
  logic [`BP_ADDR_W-1:0] tgt_mem [0:`BP_ENTRIES-1];
  ctr_e                  ctr_mem [0:`BP_ENTRIES-1];

  // lookup side decode
  logic [`BP_IDX_W-1:0] lk_idx;
  logic [`BP_TAG_W-1:0] lk_tag;
  logic                 lk_hit;
  ctr_e                 lk_ctr;

  assign lk_idx = lookup_pc[`BP_IDX_W+1:2];          // bits just above byte offset
  assign lk_tag = lookup_pc[`BP_ADDR_W-1:`BP_IDX_W+2]; // everything above index
  assign lk_ctr = ctr_mem[lk_idx];

  // hit needs a live entry with a matching tag
  assign lk_hit = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);

  always_comb begin
    pred.hit    = lk_hit;
    pred.taken  = lk_hit && ((lk_ctr == weak_t) || (lk_ctr == strong_t)); // upper half
    pred.target = lk_hit ? tgt_mem[lk_idx] : '0;     // zero on miss
    pred.ctr    = lk_hit ? lk_ctr : strong_nt;       // miss reads as strong_nt
  end

  // second read port, raw entry for the update read-modify-write
  always_comb begin
    rd_entry.valid  = valid_q[rd_idx];
    rd_entry.tag    = tag_mem[rd_idx];
    rd_entry.target = tgt_mem[rd_idx];
    rd_entry.ctr    = ctr_mem[rd_idx];
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;                                 // whole table invalid
    end else if (wr_en) begin
      valid_q[wr_idx] <= wr_entry.valid;
    end
  end

  // tag, target and counter payload
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= wr_entry.tag;
      tgt_mem[wr_idx] <= wr_entry.target;
      ctr_mem[wr_idx] <= wr_entry.ctr;               // new counter visible next cycle
    end
  end

endmodule

/* hdl/btb_update_ctrl.sv */
// ----------------------------------------------------------
// four-phase req/ack receiver for resolved branches
// reads the indexed entry, updates counter/target, writes back
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bp_defines.svh"

module btb_update_ctrl
  import bp_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       upd_req,   // resolver request, held until ack
  input  resolve_t   upd,       // resolved branch, stable while req high
  output logic       upd_ack,
  output logic [5:0] rd_idx,    // to table rmw port
  input  btb_entry_t rd_entry,
  output logic       wr_en,
  output logic [5:0] wr_idx,
  output btb_entry_t wr_entry
);

  upd_state_e state;

  logic [`BP_TAG_W-1:0] upd_tag;
  logic                 tag_hit;
  btb_entry_t           new_entry;

  // step counter toward strong_t
  function automatic ctr_e ctr_up(input ctr_e c);
    case (c)
      strong_nt: return weak_nt;
      weak_nt:   return weak_t;
      default:   return strong_t;   // weak_t and strong_t saturate here
    endcase
  endfunction

  // step counter toward strong_nt
  function automatic ctr_e ctr_down(input ctr_e c);
    case (c)
      strong_t: return weak_t;
      weak_t:   return weak_nt;
      default:  return strong_nt;
    endcase
  endfunction

  assign rd_idx  = upd.pc[`BP_IDX_W+1:2];
  assign wr_idx  = rd_idx;                            // write back where we read
  assign upd_tag = upd.pc[`BP_ADDR_W-1:`BP_IDX_W+2];
  assign tag_hit = rd_entry.valid && (rd_entry.tag == upd_tag);

  // new entry by the update rule
  always_comb begin
    new_entry = rd_entry;
    if (tag_hit) begin
      if (upd.taken) begin
        new_entry.ctr    = ctr_up(rd_entry.ctr);
        new_entry.target = upd.target;                // latest target wins
      end else begin
        new_entry.ctr    = ctr_down(rd_entry.ctr);    // target kept
      end
    end else begin
      new_entry.valid  = 1'b1;                        // allocate, evicts old occupant
      new_entry.tag    = upd_tag;
      new_entry.target = upd.target;
      new_entry.ctr    = weak_t;
    end
  end

  assign wr_entry = new_entry;
  // not-taken miss writes nothing
  assign wr_en = (state == write) && (tag_hit || upd.taken);

  // handshake FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      upd_ack <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (upd_req) state <= write;               // phase 1 seen
        end
        write: begin
          state   <= hold_ack;
          upd_ack <= 1'b1;                            // table written this edge
        end
        hold_ack: begin
          if (!upd_req) begin                         // phase 3 seen
            state   <= idle;
            upd_ack <= 1'b0;
          end
        end
        default: begin
          state   <= idle;
          upd_ack <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* hdl/fetch_pc_gen.sv */
// ----------------------------------------------------------
// fetch pc register with next-pc selection
// priority is redirect, then taken prediction, then pc + 4
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bp_defines.svh"

module fetch_pc_gen
  import bp_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        fetch_en,   // low stalls the pc
  input  redirect_t   redirect,   // from a later stage, wins over everything
  input  pred_t       pred,       // btb lookup of fetch_pc
  output logic [31:0] fetch_pc
);

  // sequential fetch step, one 32-bit instruction
  localparam logic [`BP_ADDR_W-1:0] pc_step = `BP_ADDR_W'(4);

  logic [`BP_ADDR_W-1:0] pc_q;
  logic [`BP_ADDR_W-1:0] pc_next;
  logic [`BP_ADDR_W-1:0] pc_seq;
  logic                  use_pred;

  assign pc_seq   = pc_q + pc_step;
  assign use_pred = fetch_en && pred.taken;         // hit with counter in taken half

  // next-pc select
  always_comb begin
    if (redirect.valid) begin
      pc_next = redirect.pc;                        // mispredict / jump fixup
    end else if (use_pred) begin
      pc_next = pred.target;
    end else if (fetch_en) begin
      pc_next = pc_seq;
    end else begin
      pc_next = pc_q;                               // stall, lookup keeps running
    end
  end

  // pc register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= `BP_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign fetch_pc = pc_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the branch predictor testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module branch_predictor_tb \
  -f build.f -o sim_bp

./obj_dir/sim_bp | tee sim.log

if grep -q "^Test passed$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* test/bp_tests.txt */
# U pc target taken | P pc hit taken target ctr | S pc stall_cycles (all hex but stall)
# ctr: 0 strong_nt, 1 weak_nt, 2 weak_t, 3 strong_t
P 00000100 0 0 00000000 0
U 00000040 00000800 1
P 00000040 1 1 00000800 2
U 00000040 00000800 1
U 00000040 00000800 1
P 00000040 1 1 00000800 3
U 00000040 00000000 0
U 00000040 00000000 0
P 00000040 1 0 00000800 1
U 00001040 00002000 1
P 00000040 0 0 00000000 0
P 00001040 1 1 00002000 2
U 00000088 00000300 0
P 00000088 0 0 00000000 0
U 00002040 00000500 0
P 00001040 1 1 00002000 2
S 00001040 5
P 00000200 0 0 00000000 0
U 000000c0 00000040 1
P 000000c0 1 1 00000040 2
U 000000c0 00000000 0
U 000000c0 00000000 0
U 000000c0 00000000 0
P 000000c0 1 0 00000040 0
S 00000300 3
P 00000304 0 0 00000000 0
U 00000300 00000100 1
P 00000300 1 1 00000100 2

/* test/branch_predictor_assertions.sv */
// ----------------------------------------------------------
// handshake and FSM properties of the update controller
// bound into btb_update_ctrl from the testbench top
// ----------------------------------------------------------
`timescale 1ns/1ps

module branch_predictor_assertions
  import bp_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       upd_req,
  input resolve_t   upd,
  input logic       upd_ack,
  input logic       wr_en,
  input upd_state_e state
);

  // no ack while waiting for a request
  idle_ack_low: assert property (@(posedge clk) disable iff (reset)
    (state == idle) |-> !upd_ack)
    else $error("upd_ack high in idle");

  // table writes only from the write state with the request still up
  write_only_in_write: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> ((state == write) && upd_req))
    else $error("wr_en outside the write state or without upd_req");

  // ack may only drop once the request is gone
  ack_holds_under_req: assert property (@(posedge clk) disable iff (reset)
    $fell(upd_ack) |-> !$past(upd_req))
    else $error("upd_ack fell while upd_req high");

  // resolver keeps the branch payload still during the request
  upd_stable_under_req: assert property (@(posedge clk) disable iff (reset)
    (upd_req && $past(upd_req)) |-> $stable(upd))
    else $error("upd changed while upd_req high");

endmodule

/* test/branch_predictor_tb.sv */
// ----------------------------------------------------------
// testbench for the branch predictor top level
// replays test/bp_tests.txt, checks pred, fetch_pc and the handshake
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "bp_defines.svh"

module branch_predictor_tb
  import bp_pkg::*;
();

  logic        clk;
  logic        reset;
  logic        fetch_en;
  redirect_t   redirect;
  logic        upd_req;
  resolve_t    upd;
  logic        upd_ack;
  logic [31:0] fetch_pc;
  pred_t       pred;

  int errors;
  int checks;
  int fd;

  // expected table contents, kept by the update rule
  logic                  m_valid [0:`BP_ENTRIES-1];
  logic [`BP_TAG_W-1:0]  m_tag   [0:`BP_ENTRIES-1];
  logic [`BP_ADDR_W-1:0] m_tgt   [0:`BP_ENTRIES-1];
  logic [1:0]            m_ctr   [0:`BP_ENTRIES-1];

  tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

  branch_predictor_top UUT (
    .clk      (clk),
    .reset    (reset),
    .fetch_en (fetch_en),
    .redirect (redirect),
    .upd_req  (upd_req),
    .upd      (upd),
    .upd_ack  (upd_ack),
    .fetch_pc (fetch_pc),
    .pred     (pred)
  );

  bind btb_update_ctrl branch_predictor_assertions u_upd_checks (
    .clk     (clk),
    .reset   (reset),
    .upd_req (upd_req),
    .upd     (upd),
    .upd_ack (upd_ack),
    .wr_en   (wr_en),
    .state   (state)
  );

  task automatic compare_pred(input logic eh, input logic et, input logic [31:0] etg,
                              input logic [1:0] ec, input string what);
    checks++;
    if (pred.hit !== eh || pred.taken !== et || pred.target !== etg || pred.ctr !== ec) begin
      errors++;
      $display("FAILED at %0t: %s pc %h got hit %b taken %b target %h ctr %0d, exp %b %b %h %0d",
               $time, what, fetch_pc, pred.hit, pred.taken, pred.target, pred.ctr,
               eh, et, etg, ec);
    end
  endtask

  task automatic verify_fetch_pc(input logic [31:0] exp_pc, input string what);
    checks++;
    if (fetch_pc !== exp_pc) begin
      errors++;
      $display("FAILED at %0t: %s fetch_pc %h, expected %h", $time, what, fetch_pc, exp_pc);
    end
  endtask

  // prediction the reference table gives for pc
  task automatic expect_model_pred(input logic [31:0] pc, input string what);
    logic [5:0] i;
    logic       h;
    i = pc[7:2];
    h = m_valid[i] && (m_tag[i] == pc[31:8]);
    compare_pred(h, h && m_ctr[i][1], h ? m_tgt[i] : 32'h0, h ? m_ctr[i] : 2'd0, what);
  endtask

  task automatic apply_update_rule(input logic [31:0] pc, input logic [31:0] tgt,
                                   input logic tk);
    logic [5:0] i;
    logic       h;
    i = pc[7:2];
    h = m_valid[i] && (m_tag[i] == pc[31:8]);
    if (h && tk) begin
      m_ctr[i] = (m_ctr[i] == 2'd3) ? 2'd3 : m_ctr[i] + 2'd1;  // saturate at strong_t
      m_tgt[i] = tgt;
    end else if (h) begin
      m_ctr[i] = (m_ctr[i] == 2'd0) ? 2'd0 : m_ctr[i] - 2'd1;  // target kept
    end else if (tk) begin
      m_valid[i] = 1'b1;     // allocate over the old occupant
      m_tag[i]   = pc[31:8];
      m_tgt[i]   = tgt;
      m_ctr[i]   = 2'd2;     // weak_t
    end
  endtask

  // one four-phase update, with fetch parked on the updated pc
  task automatic handshake_update(input logic [31:0] pc, input logic [31:0] tgt,
                                  input logic tk);
    int cycles;
    upd.pc         = pc;
    upd.target     = tgt;
    upd.taken      = tk;
    redirect.valid = 1'b1;
    redirect.pc    = pc;
    fetch_en       = 1'b0;
    upd_req        = 1'b1;
    @(negedge clk);          // req seen so FSM is in write
    cycles = 1;
    verify_fetch_pc(pc, "update park");
    expect_model_pred(pc, "before ack");
    apply_update_rule(pc, tgt, tk);
    while (!upd_ack && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!upd_ack) begin
      errors++;
      $display("timeout: upd_ack never rose for the update at pc %h", pc);
    end else begin
      checks++;
      if (cycles != 2) begin
        errors++;
        $display("FAILED at %0t: upd_ack rose after %0d edges, expected 2", $time, cycles);
      end
      expect_model_pred(pc, "after ack");
    end
    upd_req        = 1'b0;
    redirect.valid = 1'b0;
    cycles = 0;
    while (upd_ack && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (upd_ack) begin
      errors++;
      $display("timeout: upd_ack stayed high after upd_req dropped at pc %h", pc);
    end
  endtask

  // redirect to pc, check the lookup, then the next fetch address
  task automatic probe_pc(input logic [31:0] pc, input logic eh, input logic et,
                          input logic [31:0] etg, input logic [1:0] ec);
    redirect.valid = 1'b1;
    redirect.pc    = pc;
    fetch_en       = 1'b1;
    @(negedge clk);
    redirect.valid = 1'b0;
    verify_fetch_pc(pc, "probe redirect");
    compare_pred(eh, et, etg, ec, "probe");
    @(negedge clk);
    verify_fetch_pc(et ? etg : pc + 32'd4, "probe next");
    fetch_en = 1'b0;
  endtask

  task automatic stall_at(input logic [31:0] pc, input int n);
    redirect.valid = 1'b1;
    redirect.pc    = pc;
    fetch_en       = 1'b0;
    @(negedge clk);
    redirect.valid = 1'b0;
    repeat (n) @(negedge clk);  // stalled while lookups stay live
    verify_fetch_pc(pc, "stall hold");
  endtask

  task automatic replay_test_file();
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    int          n;
    int          cnt;
    string       rest;
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) break;
      if (op == "#") begin
        n = $fgets(rest, fd);   // comment line
      end else if (op == "U") begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        if (n == 3) begin
          handshake_update(a, b, c[0]);
        end else begin
          errors++;
          $display("an update line in the test data file has missing fields");
        end
      end else if (op == "P") begin
        n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
        if (n == 5) begin
          probe_pc(a, b[0], c[0], d, e[1:0]);
        end else begin
          errors++;
          $display("a probe line in the test data file has missing fields");
        end
      end else if (op == "S") begin
        n = $fscanf(fd, "%h %d", a, cnt);
        if (n == 2) begin
          stall_at(a, cnt);
        end else begin
          errors++;
          $display("a stall line in the test data file has missing fields");
        end
      end else begin
        errors++;
        $display("unknown operation %c in the test data file", op);
      end
    end
  endtask

  initial begin
    int cycles;
    fetch_en = 1'b0;
    redirect = '0;
    upd_req  = 1'b0;
    upd      = '0;
    errors   = 0;
    checks   = 0;
    for (int i = 0; i < `BP_ENTRIES; i++) m_valid[i] = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (reset && cycles < 40) begin
      @(negedge clk);
      cycles++;
    end
    if (reset) begin
      errors++;
      $display("timeout: reset was never released");
    end
    fd = $fopen("test/bp_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test data file test/bp_tests.txt");
    end else begin
      replay_test_file();
      $fclose(fd);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* test/tb_clock_gen.sv */
// ----------------------------------------------------------
// testbench clock, 4 ns period, and a 16-cycle sync reset
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 250 MHz
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);          // release away from the active edge
    reset = 1'b0;
  end

endmodule
